/* hw/arith_pkg.sv */
package arith_pkg;

   // operand and product widths
   localparam int op_w   = 7;
   localparam int prod_w = 2 * op_w;

   typedef logic signed [op_w-1:0]   operand_t;
   typedef logic signed [prod_w-1:0] product_t;

   // multiplicand a, multiplier b
   typedef struct packed {
      operand_t a;
      operand_t b;
   } op_pair_t;

   // word handed from one array row to the next
   typedef struct packed {
      logic     valid;
      op_pair_t ops;
      product_t sum;
      product_t carry;
   } csa_word_t;

endpackage

/* hw/flow_pkg.sv */
package flow_pkg;

   // enough for a buffer of depth 8
   localparam int credit_w = 4;

   typedef logic [credit_w-1:0] credit_t;

   // finished product leaving the final adder
   typedef struct packed {
      logic              valid;
      arith_pkg::product_t product;
   } product_beat_t;

endpackage

/* hw/pp_row_stage.sv */
`timescale 1ns/1ps

module pp_row_stage #(
   parameter int OP_W = arith_pkg::op_w,
   parameter int ROW  = 1
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  arith_pkg::csa_word_t row_in,
   output arith_pkg::csa_word_t row_out
);

   import arith_pkg::*;

   // top multiplier bit carries negative weight
   localparam bit is_sign_row = (ROW == OP_W - 1);

   product_t a_ext;
   product_t pp;
   product_t s_next;
   product_t c_next;

   always_comb begin
      // extend first so that -64 negates cleanly
      a_ext = product_t'($signed(row_in.ops.a));
      if (is_sign_row) begin
         pp = -a_ext;
      end else begin
         pp = a_ext;
      end
      if (!row_in.ops.b[ROW]) begin
         pp = '0;
      end
      pp = pp << ROW;

      // full-adder row, carries move up one weight
      s_next = row_in.sum ^ row_in.carry ^ pp;
      c_next = ((row_in.sum & row_in.carry) |
                (row_in.sum & pp) |
                (row_in.carry & pp)) << 1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         row_out <= '0;
      end else begin
         row_out.valid <= row_in.valid;
         row_out.ops   <= row_in.ops;
         row_out.sum   <= s_next;
         row_out.carry <= c_next;
      end
   end

endmodule

/* hw/csa_array.sv */
`timescale 1ns/1ps

module csa_array #(
   parameter int OP_W = arith_pkg::op_w
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  arith_pkg::op_pair_t  in_ops,
   output arith_pkg::csa_word_t row_out
);

   import arith_pkg::*;

   product_t  a_ext;
   product_t  pp0;
   csa_word_t first_q;
   csa_word_t chain [OP_W];

   // row 0: multiplicand gated by b[0], sign extended to product width
   always_comb begin
      a_ext = product_t'($signed(in_ops.a));
      pp0   = in_ops.b[0] ? a_ext : '0;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         first_q <= '0;
      end else begin
         first_q.valid <= in_valid;
         first_q.ops   <= in_ops;
         first_q.sum   <= pp0;
         first_q.carry <= '0;
      end
   end

   assign chain[0] = first_q;

   // one registered row per remaining multiplier bit
   for (genvar r = 1; r < OP_W; r++) begin : g_row
      pp_row_stage #(
         .OP_W (OP_W),
         .ROW  (r)
      ) u_row (
         .clk     (clk),
         .rst_n   (rst_n),
         .row_in  (chain[r-1]),
         .row_out (chain[r])
      );
   end

   assign row_out = chain[OP_W-1];

endmodule

/* hw/final_adder.sv */
`timescale 1ns/1ps

module final_adder (
   input  logic                    clk,
   input  logic                    rst_n,
   input  arith_pkg::csa_word_t    row_in,
   output flow_pkg::product_beat_t beat
);

   import arith_pkg::*;

   product_t        sum_bits;
   logic [prod_w:0] ripple;

   // ripple carry across the full product width, top carry dropped
   always_comb begin
      ripple[0] = 1'b0;
      for (int i = 0; i < prod_w; i++) begin
         sum_bits[i]  = row_in.sum[i] ^ row_in.carry[i] ^ ripple[i];
         ripple[i+1]  = (row_in.sum[i] & row_in.carry[i]) |
                        (row_in.sum[i] & ripple[i]) |
                        (row_in.carry[i] & ripple[i]);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat <= '0;
      end else begin
         beat.valid   <= row_in.valid;
         beat.product <= sum_bits;
      end
   end

endmodule

/* hw/result_buffer.sv */
`timescale 1ns/1ps

module result_buffer #(
   parameter int BUF_DEPTH = 8
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  flow_pkg::product_beat_t beat,
   input  logic                    pop,
   output logic                    not_empty,
   output arith_pkg::product_t     head,
   output logic                    in_credit
);

   import arith_pkg::*;

   localparam int ptr_w = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int cnt_w = $clog2(BUF_DEPTH + 1);

   product_t         mem [BUF_DEPTH];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             wr_en;
   logic             rd_en;

   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
      return (p == ptr_w'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign wr_en     = beat.valid;
   assign not_empty = (count != '0);
   assign rd_en     = pop & not_empty;
   assign head      = mem[rd_ptr];
   // every slot freed goes back to the source
   assign in_credit = rd_en;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= beat.product;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* hw/credit_sender.sv */
`timescale 1ns/1ps

module credit_sender #(
   parameter int SINK_CREDITS = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                not_empty,
   input  arith_pkg::product_t head,
   input  logic                out_credit,
   output logic                pop,
   output logic                out_valid,
   output arith_pkg::product_t out_product
);

   import flow_pkg::*;

   credit_t credits;

   // send only while the sink has room
   assign pop         = not_empty && (credits != '0);
   assign out_valid   = pop;
   assign out_product = head;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits <= credit_t'(SINK_CREDITS);
      end else begin
         // return and spend in one cycle cancel out
         case ({out_credit, pop})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

/* hw/array_mul_top.sv */
`timescale 1ns/1ps

module array_mul_top #(
   parameter int OP_W         = arith_pkg::op_w,
   parameter int BUF_DEPTH    = 8,
   parameter int SINK_CREDITS = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   input  arith_pkg::op_pair_t in_ops,
   output logic                in_credit,
   output logic                out_valid,
   output arith_pkg::product_t out_product,
   input  logic                out_credit
);

   import arith_pkg::*;
   import flow_pkg::*;

   csa_word_t     array_out;
   product_beat_t sum_beat;
   product_t      head;
   logic          not_empty;
   logic          pop;

   csa_array #(
      .OP_W (OP_W)
   ) u_array (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_ops   (in_ops),
      .row_out  (array_out)
   );

   final_adder u_final (
      .clk    (clk),
      .rst_n  (rst_n),
      .row_in (array_out),
      .beat   (sum_beat)
   );

   result_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
   ) u_buffer (
      .clk       (clk),
      .rst_n     (rst_n),
      .beat      (sum_beat),
      .pop       (pop),
      .not_empty (not_empty),
      .head      (head),
      .in_credit (in_credit)
   );

   credit_sender #(
      .SINK_CREDITS (SINK_CREDITS)
   ) u_sender (
      .clk         (clk),
      .rst_n       (rst_n),
      .not_empty   (not_empty),
      .head        (head),
      .out_credit  (out_credit),
      .pop         (pop),
      .out_valid   (out_valid),
      .out_product (out_product)
   );

endmodule

/* include/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
   logic fb;
   fb = state[31] ^ state[21] ^ state[1] ^ state[0];
   return {state[30:0], fb};
endfunction

// one step per operand bit
function automatic arith_pkg::operand_t lfsr_operand(ref logic [31:0] state);
   arith_pkg::operand_t val;
   val = '0;
   for (int i = 0; i < arith_pkg::op_w; i++) begin
      state  = lfsr_step(state);
      val[i] = state[0];
   end
   return val;
endfunction

// exact signed product, widened before the multiply
function automatic arith_pkg::product_t ref_product(input arith_pkg::operand_t a,
                                                    input arith_pkg::operand_t b);
   arith_pkg::product_t a_ext;
   arith_pkg::product_t b_ext;
   a_ext = arith_pkg::product_t'(a);
   b_ext = arith_pkg::product_t'(b);
   return a_ext * b_ext;
endfunction

task automatic check_product(input string tag,
                             input arith_pkg::product_t got,
                             input arith_pkg::product_t exp,
                             inout int checks,
                             inout int errors);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("%s: product mismatch, got %0d expected %0d", tag, got, exp);
   end
endtask

`endif

/* testbench/tb_array_mul.sv */
`timescale 1ns/1ps

module tb_array_mul;

   import arith_pkg::*;

   `include "tb_model.svh"

   localparam int buf_depth    = 8;
   localparam int sink_credits = 4;

   // sink return policies
   localparam int sink_prompt = 0;
   localparam int sink_hold   = 1;
   localparam int sink_random = 2;

   localparam int n_corner  = 5;
   localparam int n_stream  = 200;
   localparam int n_hold    = 20;
   localparam int n_gaps    = 150;
   localparam int hold_len  = 60;
   localparam int total_ops = n_corner + n_stream + n_hold + n_gaps;
   localparam int timeout_cycles = total_ops * 20 + 500;

   logic     clk;
   logic     rst_n;
   logic     in_valid;
   op_pair_t in_ops;
   logic     in_credit;
   logic     out_valid;
   product_t out_product;
   logic     out_credit;

   logic [31:0] lfsr_state;
   op_pair_t    pending [$];
   product_t    expected [$];

   int checks;
   int errors;
   int src_credits;
   int owed;
   int sink_mode;
   int beat_count;
   int returned_count;
   int pulse_count;
   int accept_count;
   int cycle_count;
   int test_checks;
   int test_errors;
   logic seen_valid;
   logic seen_credit;
   string test_name;

   array_mul_top #(
      .OP_W         (op_w),
      .BUF_DEPTH    (buf_depth),
      .SINK_CREDITS (sink_credits)
   ) dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_ops      (in_ops),
      .in_credit   (in_credit),
      .out_valid   (out_valid),
      .out_product (out_product),
      .out_credit  (out_credit)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // one clock of source and sink activity, outputs read at the falling edge
   task automatic drive_cycle(input logic want_send);
      op_pair_t ops;
      logic     send;
      logic     ret;
      product_t exp;
      ops  = '0;
      send = 1'b0;
      ret  = 1'b0;
      @(posedge clk);
      #2;
      if (want_send && src_credits > 0 && pending.size() > 0) begin
         ops  = pending.pop_front();
         send = 1'b1;
         src_credits--;
         accept_count++;
         expected.push_back(ref_product(ops.a, ops.b));
      end
      if (owed > 0) begin
         case (sink_mode)
            sink_prompt: ret = 1'b1;
            sink_random: begin
               lfsr_state = lfsr_step(lfsr_state);
               ret = lfsr_state[0];
            end
            default: ret = 1'b0;
         endcase
      end
      if (ret) begin
         owed--;
         returned_count++;
      end
      in_valid   = send;
      in_ops     = ops;
      out_credit = ret;

      @(negedge clk);
      seen_valid  = out_valid;
      seen_credit = in_credit;
      if (in_credit) begin
         pulse_count++;
         src_credits++;
      end
      if (out_valid) begin
         beat_count++;
         owed++;
         if (expected.size() == 0) begin
            errors++;
            $display("ERR t=%0t %s: out_valid with no product outstanding", $time, test_name);
         end else begin
            exp = expected.pop_front();
            check_product($sformatf("ERR t=%0t %s beat", $time, test_name),
                          out_product, exp, checks, errors);
         end
      end
      if (beat_count > sink_credits + returned_count) begin
         errors++;
         $display("ERR t=%0t %s: %0d beats sent but only %0d sink credits given", $time,
                  test_name, beat_count, sink_credits + returned_count);
      end
   endtask

   // run until every queued pair has come back and the sink owes nothing
   task automatic run_traffic(input int mode);
      sink_mode = mode;
      while (pending.size() > 0 || expected.size() > 0 || owed > 0) begin
         drive_cycle(1'b1);
      end
   endtask

   task automatic queue_random(input int n);
      op_pair_t ops;
      for (int i = 0; i < n; i++) begin
         ops.a = lfsr_operand(lfsr_state);
         ops.b = lfsr_operand(lfsr_state);
         pending.push_back(ops);
      end
   endtask

   task automatic queue_pair(input int a, input int b);
      op_pair_t ops;
      ops.a = operand_t'(a);
      ops.b = operand_t'(b);
      pending.push_back(ops);
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic report_test(input int num);
      $display("test %0d %s: %0d checks, %0d errors", num, test_name,
               checks - test_checks, errors - test_errors);
   endtask

   task automatic check_idle(input string tag);
      check_product($sformatf("ERR t=%0t %s out_valid", $time, tag),
                    product_t'(seen_valid), '0, checks, errors);
      check_product($sformatf("ERR t=%0t %s in_credit", $time, tag),
                    product_t'(seen_credit), '0, checks, errors);
   endtask

   initial begin
      int base;
      rst_n       = 1'b0;
      in_valid    = 1'b0;
      in_ops      = '0;
      out_credit  = 1'b0;
      lfsr_state  = 32'h430b6203;
      checks      = 0;
      errors      = 0;
      src_credits = buf_depth;
      owed        = 0;
      sink_mode   = sink_prompt;
      beat_count     = 0;
      returned_count = 0;
      pulse_count    = 0;
      accept_count   = 0;

      begin_test("reset_idle");
      repeat (8) begin
         drive_cycle(1'b0);
         check_idle("in reset");
      end
      @(posedge clk);
      #2;
      rst_n = 1'b1;
      repeat (8) begin
         drive_cycle(1'b0);
         check_idle("after reset");
      end
      report_test(1);

      begin_test("corner_pairs");
      queue_pair(-64, -64);
      queue_pair(-64, 63);
      queue_pair(63, 63);
      queue_pair(0, -64);
      queue_pair(-1, -1);
      run_traffic(sink_prompt);
      report_test(2);

      begin_test("random_stream");
      queue_random(n_stream);
      run_traffic(sink_prompt);
      report_test(3);

      // sink holds back, only the initial credits may be spent
      begin_test("sink_hold");
      queue_random(n_hold);
      sink_mode = sink_hold;
      base = beat_count;
      repeat (hold_len) drive_cycle(1'b1);
      check_product($sformatf("ERR t=%0t %s beats while held", $time, test_name),
                    product_t'(beat_count - base), product_t'(sink_credits), checks, errors);
      run_traffic(sink_prompt);
      report_test(4);

      begin_test("credit_gaps");
      queue_random(n_gaps);
      run_traffic(sink_random);
      check_product($sformatf("ERR t=%0t %s in_credit pulses", $time, test_name),
                    product_t'(pulse_count), product_t'(beat_count), checks, errors);
      check_product($sformatf("ERR t=%0t %s accepted pairs", $time, test_name),
                    product_t'(accept_count), product_t'(beat_count), checks, errors);
      check_product($sformatf("ERR t=%0t %s source credits", $time, test_name),
                    product_t'(src_credits), product_t'(buf_depth), checks, errors);
      report_test(5);

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Checks failed");
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
hw/arith_pkg.sv
hw/flow_pkg.sv
hw/pp_row_stage.sv
hw/csa_array.sv
hw/final_adder.sv
hw/result_buffer.sv
hw/credit_sender.sv
hw/array_mul_top.sv
testbench/tb_array_mul.sv

/* run_sim.sh */
#!/bin/sh
# build and run the array multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
   -f flist.f \
   --top-module tb_array_mul \
   --Mdir obj_dir \
   -o tb_array_mul

./obj_dir/tb_array_mul | tee sim.log

if grep -q "Checks failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
